// ==== compile.f ====
hdl/surfacePkg.sv
hdl/renderStateRegs.sv
hdl/surfaceControl.sv
hdl/closestHit.sv
hdl/surfaceShade.sv
hdl/surfaceUnit.sv
testbench/clockGen.sv
testbench/surfaceUnit_asserts.sv
testbench/tbSurfaceUnit.sv

// ==== hdl/closestHit.sv ====
/* Closest-hit tracker */

`timescale 1ns/1ns

module closestHit import surfacePkg::*; #(
    parameter int FRAC_BITS = 16
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        trackerClear,

    // Candidate stream
    input  logic        hitValid,
    input  fixedT       hitT,
    input  primIndexT   hitPrim,
    input  surfaceTypeT hitSurface,
    input  colorT       hitColor,

    input  colorT       clearColor,

    // Current ray
    input  fixedT       curOrigX,
    input  fixedT       curOrigY,
    input  fixedT       curOrigZ,
    input  fixedT       curDirX,
    input  fixedT       curDirY,
    input  fixedT       curDirZ,

    output surfaceTypeT bestSurface,
    output primIndexT   bestPrim,
    output colorT       bestColor,
    output fixedT       bestT,
    output fixedT       hitPosX,
    output fixedT       hitPosY,
    output fixedT       hitPosZ
);

    logic closer;

    // Origin plus T times direction on one axis
    function automatic fixedT axisPos(input fixedT orig, input fixedT dir, input fixedT t);
        logic signed [63:0] prod;
        fixedT              scaled;
        prod   = t * dir;
        scaled = prod[FRAC_BITS +: 32];
        return orig + scaled;
    endfunction

    // Strictly smaller T wins, so the first of equal hits stays
    assign closer = hitValid && (hitSurface != stNone) && (hitT < bestT);

    // --------------------
    // Best hit register

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            bestSurface <= stNone;
            bestPrim    <= '0;
            bestColor   <= '0;
            bestT       <= FIXED_MAX;
        end else if (trackerClear) begin
            // Miss until a candidate says otherwise
            bestSurface <= stNone;
            bestPrim    <= '0;
            bestColor   <= clearColor;
            bestT       <= FIXED_MAX;
        end else if (closer) begin
            bestSurface <= hitSurface;
            bestPrim    <= hitPrim;
            bestColor   <= hitColor;
            bestT       <= hitT;
        end
    end

    // --------------------
    // Hit position

    assign hitPosX = axisPos(curOrigX, curDirX, bestT);
    assign hitPosY = axisPos(curOrigY, curDirY, bestT);
    assign hitPosZ = axisPos(curOrigZ, curDirZ, bestT);

endmodule

// ==== hdl/renderStateRegs.sv ====
/* Render-state registers */

`timescale 1ns/1ns

module renderStateRegs import surfacePkg::*; (
    input  logic        clk,
    input  logic        resetn,

    // Write port
    input  logic        cfgWrite,
    input  cfgAddrT     cfgAddr,
    input  logic [31:0] cfgData,

    // Render state
    output colorT       clearColor,
    output fixedT       lightDirX,
    output fixedT       lightDirY,
    output fixedT       lightDirZ,
    output primIndexT   groundPrim
);

    // --------------------
    // Register writes

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            clearColor <= '0;
            lightDirX  <= '0;
            lightDirY  <= '0;
            lightDirZ  <= '0;
            groundPrim <= '0;
        end else if (cfgWrite) begin
            case (cfgAddr)
                CFG_CLEAR_COLOR: begin
                    // Colour of rays that hit nothing
                    clearColor <= cfgData[23:0];
                end
                CFG_LIGHT_X: begin
                    lightDirX <= cfgData;
                end
                CFG_LIGHT_Y: begin
                    lightDirY <= cfgData;
                end
                CFG_LIGHT_Z: begin
                    lightDirZ <= cfgData;
                end
                CFG_GROUND_PRIM: begin
                    // Primitive that gets the checker texture
                    groundPrim <= cfgData[11:0];
                end
                default: begin
                    // Unmapped address, write dropped
                end
            endcase
        end
    end

endmodule

// ==== hdl/surfaceControl.sv ====
/* Ray buffer and surfacing FSM */

`timescale 1ns/1ns

module surfaceControl import surfacePkg::*; (
    input  logic   clk,
    input  logic   resetn,

    // Ray input
    input  logic   addInput,
    input  fixedT  rayOrigX,
    input  fixedT  rayOrigY,
    input  fixedT  rayOrigZ,
    input  fixedT  rayDirX,
    input  fixedT  rayDirY,
    input  fixedT  rayDirZ,
    input  pixelT  pixelX,
    input  pixelT  pixelY,
    input  bounceT bounceLevel,
    input  colorT  lastColor,

    input  logic   candDone,
    input  logic   outputFull,

    output logic   fifoFull,
    output logic   rayStart,
    output logic   trackerClear,
    output logic   shadeLoad,

    // Ray being surfaced
    output fixedT  curOrigX,
    output fixedT  curOrigY,
    output fixedT  curOrigZ,
    output fixedT  curDirX,
    output fixedT  curDirY,
    output fixedT  curDirZ,
    output pixelT  curPixelX,
    output pixelT  curPixelY,
    output bounceT curBounce,
    output colorT  curLastColor
);

    surfStateT state;
    logic      acceptRay;
    logic      takeRay;

    // Buffered ray waiting for the FSM
    fixedT  slotOrigX, slotOrigY, slotOrigZ;
    fixedT  slotDirX, slotDirY, slotDirZ;
    pixelT  slotPixelX, slotPixelY;
    bounceT slotBounce;
    colorT  slotLastColor;

    assign acceptRay    = addInput && !fifoFull;
    assign takeRay      = (state == sInit) && fifoFull;
    // Tracker is cleared on the same edge the ray moves in
    assign trackerClear = takeRay;
    // Output record loads at the edge that leaves sDone
    assign shadeLoad    = (state == sDone) && !outputFull;

    // --------------------
    // FSM and slot flag

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state    <= sInit;
            fifoFull <= 1'b0;
            rayStart <= 1'b0;
        end else begin
            rayStart <= 1'b0;
            if (acceptRay) begin
                fifoFull <= 1'b1;
            end
            case (state)
                sInit: begin
                    if (fifoFull) begin
                        state    <= sSurfacing;
                        rayStart <= 1'b1;
                        fifoFull <= 1'b0;
                    end
                end
                sSurfacing: begin
                    if (candDone) begin
                        state <= sDone;
                    end
                end
                sDone: begin
                    // Hold here while downstream is full
                    if (!outputFull) begin
                        state <= sInit;
                    end
                end
                default: begin
                    state <= sInit;
                end
            endcase
        end
    end

    // --------------------
    // Ray payload

    always_ff @(posedge clk) begin
        if (acceptRay) begin
            slotOrigX     <= rayOrigX;
            slotOrigY     <= rayOrigY;
            slotOrigZ     <= rayOrigZ;
            slotDirX      <= rayDirX;
            slotDirY      <= rayDirY;
            slotDirZ      <= rayDirZ;
            slotPixelX    <= pixelX;
            slotPixelY    <= pixelY;
            slotBounce    <= bounceLevel;
            slotLastColor <= lastColor;
        end
        if (takeRay) begin
            curOrigX     <= slotOrigX;
            curOrigY     <= slotOrigY;
            curOrigZ     <= slotOrigZ;
            curDirX      <= slotDirX;
            curDirY      <= slotDirY;
            curDirZ      <= slotDirZ;
            curPixelX    <= slotPixelX;
            curPixelY    <= slotPixelY;
            curBounce    <= slotBounce;
            curLastColor <= slotLastColor;
        end
    end

endmodule

// ==== hdl/surfacePkg.sv ====
/* Surfacing stage shared types */

package surfacePkg;

    // --------------------
    // Fixed-point and payload types

    // Q16.16 signed value for T, coordinates and directions
    typedef logic signed [31:0] fixedT;

    // Largest positive value, marks no hit yet
    localparam fixedT FIXED_MAX = 32'sh7FFF_FFFF;

    // RGB, 8 bits per channel, red in the top byte
    typedef logic [23:0] colorT;

    typedef logic [11:0] primIndexT;
    typedef logic [15:0] pixelT;
    typedef logic [3:0]  bounceT;

    // --------------------
    // Enumerations

    typedef enum logic [1:0] {
        stNone,
        stDiffuse,
        stReflect
    } surfaceTypeT;

    // Surfacing FSM states
    typedef enum logic [1:0] {
        sInit,
        sSurfacing,
        sDone
    } surfStateT;

    // --------------------
    // Render-state register map

    typedef logic [2:0] cfgAddrT;

    localparam cfgAddrT CFG_CLEAR_COLOR = 3'd0;
    localparam cfgAddrT CFG_LIGHT_X     = 3'd1;
    localparam cfgAddrT CFG_LIGHT_Y     = 3'd2;
    localparam cfgAddrT CFG_LIGHT_Z     = 3'd3;
    localparam cfgAddrT CFG_GROUND_PRIM = 3'd4;

endpackage

// ==== hdl/surfaceShade.sv ====
/* Surface record output */

`timescale 1ns/1ns

module surfaceShade import surfacePkg::*; #(
    parameter int CHECKER_BIT = 18
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        shadeLoad,

    // Best hit
    input  surfaceTypeT bestSurface,
    input  primIndexT   bestPrim,
    input  colorT       bestColor,
    input  fixedT       hitPosX,
    input  fixedT       hitPosY,
    input  fixedT       hitPosZ,

    // Render state
    input  fixedT       lightDirX,
    input  fixedT       lightDirY,
    input  fixedT       lightDirZ,
    input  primIndexT   groundPrim,

    // Ray pass-through
    input  pixelT       curPixelX,
    input  pixelT       curPixelY,
    input  bounceT      curBounce,
    input  colorT       curLastColor,

    // Output record
    output logic        valid,
    output colorT       outColor,
    output surfaceTypeT outSurface,
    output primIndexT   outPrim,
    output fixedT       outHitPosX,
    output fixedT       outHitPosY,
    output fixedT       outHitPosZ,
    output fixedT       outShadowDirX,
    output fixedT       outShadowDirY,
    output fixedT       outShadowDirZ,
    output pixelT       outPixelX,
    output pixelT       outPixelY,
    output bounceT      outBounce,
    output colorT       outLastColor
);

    logic darkSquare;

    // Alternate squares of the ground get darker
    assign darkSquare = (bestSurface != stNone) && (bestPrim == groundPrim) &&
                        (hitPosX[CHECKER_BIT] != hitPosZ[CHECKER_BIT]);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else begin
            valid <= shadeLoad;
        end
    end

    always_ff @(posedge clk) begin
        if (shadeLoad) begin
            if (darkSquare) begin
                // Each channel shifted right by one
                outColor <= {1'b0, bestColor[23:17], 1'b0, bestColor[15:9],
                             1'b0, bestColor[7:1]};
            end else begin
                outColor <= bestColor;
            end
            outSurface <= bestSurface;
            outPrim    <= bestPrim;
            // Hit position is also the shadow ray origin
            outHitPosX    <= hitPosX;
            outHitPosY    <= hitPosY;
            outHitPosZ    <= hitPosZ;
            outShadowDirX <= lightDirX;
            outShadowDirY <= lightDirY;
            outShadowDirZ <= lightDirZ;
            outPixelX     <= curPixelX;
            outPixelY     <= curPixelY;
            outBounce     <= curBounce;
            outLastColor  <= curLastColor;
        end
    end

endmodule

// ==== hdl/surfaceUnit.sv ====
/* Surfacing stage top level */

`timescale 1ns/1ns

module surfaceUnit import surfacePkg::*; #(
    parameter int FRAC_BITS   = 16,
    parameter int CHECKER_BIT = 18
) (
    input  logic        clk,
    input  logic        resetn,

    // Ray input
    input  logic        addInput,
    input  fixedT       rayOrigX,
    input  fixedT       rayOrigY,
    input  fixedT       rayOrigZ,
    input  fixedT       rayDirX,
    input  fixedT       rayDirY,
    input  fixedT       rayDirZ,
    input  pixelT       pixelX,
    input  pixelT       pixelY,
    input  bounceT      bounceLevel,
    input  colorT       lastColor,
    output logic        fifoFull,

    // Traversal and candidates
    output logic        rayStart,
    input  logic        hitValid,
    input  fixedT       hitT,
    input  primIndexT   hitPrim,
    input  surfaceTypeT hitSurface,
    input  colorT       hitColor,
    input  logic        candDone,

    // Output record
    input  logic        outputFull,
    output logic        valid,
    output colorT       outColor,
    output surfaceTypeT outSurface,
    output primIndexT   outPrim,
    output fixedT       hitPosX,
    output fixedT       hitPosY,
    output fixedT       hitPosZ,
    output fixedT       shadowDirX,
    output fixedT       shadowDirY,
    output fixedT       shadowDirZ,
    output pixelT       outPixelX,
    output pixelT       outPixelY,
    output bounceT      outBounce,
    output colorT       outLastColor,

    // Configuration
    input  logic        cfgWrite,
    input  cfgAddrT     cfgAddr,
    input  logic [31:0] cfgData
);

    logic        trackerClear;
    logic        shadeLoad;
    fixedT       curOrigX, curOrigY, curOrigZ;
    fixedT       curDirX, curDirY, curDirZ;
    pixelT       curPixelX, curPixelY;
    bounceT      curBounce;
    colorT       curLastColor;
    colorT       clearColor;
    fixedT       lightDirX, lightDirY, lightDirZ;
    primIndexT   groundPrim;
    surfaceTypeT bestSurface;
    primIndexT   bestPrim;
    colorT       bestColor;
    fixedT       bestPosX, bestPosY, bestPosZ;

    renderStateRegs i_renderState (
        .clk        (clk),
        .resetn     (resetn),
        .cfgWrite   (cfgWrite),
        .cfgAddr    (cfgAddr),
        .cfgData    (cfgData),
        .clearColor (clearColor),
        .lightDirX  (lightDirX),
        .lightDirY  (lightDirY),
        .lightDirZ  (lightDirZ),
        .groundPrim (groundPrim)
    );

    surfaceControl i_control (
        .clk          (clk),
        .resetn       (resetn),
        .addInput     (addInput),
        .rayOrigX     (rayOrigX),
        .rayOrigY     (rayOrigY),
        .rayOrigZ     (rayOrigZ),
        .rayDirX      (rayDirX),
        .rayDirY      (rayDirY),
        .rayDirZ      (rayDirZ),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .bounceLevel  (bounceLevel),
        .lastColor    (lastColor),
        .candDone     (candDone),
        .outputFull   (outputFull),
        .fifoFull     (fifoFull),
        .rayStart     (rayStart),
        .trackerClear (trackerClear),
        .shadeLoad    (shadeLoad),
        .curOrigX     (curOrigX),
        .curOrigY     (curOrigY),
        .curOrigZ     (curOrigZ),
        .curDirX      (curDirX),
        .curDirY      (curDirY),
        .curDirZ      (curDirZ),
        .curPixelX    (curPixelX),
        .curPixelY    (curPixelY),
        .curBounce    (curBounce),
        .curLastColor (curLastColor)
    );

    // Best T stays inside, hit position carries it onward
    closestHit #(
        .FRAC_BITS (FRAC_BITS)
    ) i_closestHit (
        .clk          (clk),
        .resetn       (resetn),
        .trackerClear (trackerClear),
        .hitValid     (hitValid),
        .hitT         (hitT),
        .hitPrim      (hitPrim),
        .hitSurface   (hitSurface),
        .hitColor     (hitColor),
        .clearColor   (clearColor),
        .curOrigX     (curOrigX),
        .curOrigY     (curOrigY),
        .curOrigZ     (curOrigZ),
        .curDirX      (curDirX),
        .curDirY      (curDirY),
        .curDirZ      (curDirZ),
        .bestSurface  (bestSurface),
        .bestPrim     (bestPrim),
        .bestColor    (bestColor),
        .bestT        (),
        .hitPosX      (bestPosX),
        .hitPosY      (bestPosY),
        .hitPosZ      (bestPosZ)
    );

    surfaceShade #(
        .CHECKER_BIT (CHECKER_BIT)
    ) i_shade (
        .clk           (clk),
        .resetn        (resetn),
        .shadeLoad     (shadeLoad),
        .bestSurface   (bestSurface),
        .bestPrim      (bestPrim),
        .bestColor     (bestColor),
        .hitPosX       (bestPosX),
        .hitPosY       (bestPosY),
        .hitPosZ       (bestPosZ),
        .lightDirX     (lightDirX),
        .lightDirY     (lightDirY),
        .lightDirZ     (lightDirZ),
        .groundPrim    (groundPrim),
        .curPixelX     (curPixelX),
        .curPixelY     (curPixelY),
        .curBounce     (curBounce),
        .curLastColor  (curLastColor),
        .valid         (valid),
        .outColor      (outColor),
        .outSurface    (outSurface),
        .outPrim       (outPrim),
        .outHitPosX    (hitPosX),
        .outHitPosY    (hitPosY),
        .outHitPosZ    (hitPosZ),
        .outShadowDirX (shadowDirX),
        .outShadowDirY (shadowDirY),
        .outShadowDirZ (shadowDirZ),
        .outPixelX     (outPixelX),
        .outPixelY     (outPixelY),
        .outBounce     (outBounce),
        .outLastColor  (outLastColor)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the surfacing stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tbSurfaceUnit \
    -f compile.f -o simSurfaceUnit

# Keep running past assertion errors so the testbench can report them
output=$(./obj_dir/simSurfaceUnit +verilator+error+limit+1000 2>&1) || true
echo "$output"

if echo "$output" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1

// ==== testbench/clockGen.sv ====
/* Clock and reset source */

`timescale 1ns/1ns

module clockGen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset released on a rising edge
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

// ==== testbench/surfaceUnit_asserts.sv ====
/* Surfacing stage protocol checks */

`timescale 1ns/1ns

module surfaceUnit_asserts import surfacePkg::*; (
    input  logic      clk,
    input  logic      resetn,
    input  logic      addInput,
    input  logic      fifoFull,
    input  logic      rayStart,
    input  logic      candDone,
    input  logic      outputFull,
    input  logic      valid,
    input  surfStateT state
);

    int   failCount = 0;
    logic rayArrived;

    // Set once the first ray is offered
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rayArrived <= 1'b0;
        end else if (addInput) begin
            rayArrived <= 1'b1;
        end
    end

    // --------------------
    // Protocol properties

    slotFills: assert property (@(posedge clk) disable iff (!resetn)
        addInput && !fifoFull |=> fifoFull)
    else begin
        $error("fifoFull did not rise after an accepted ray");
        failCount++;
    end

    startPulse: assert property (@(posedge clk) disable iff (!resetn)
        rayStart |=> !rayStart)
    else begin
        $error("rayStart stayed high for more than one cycle");
        failCount++;
    end

    validPulse: assert property (@(posedge clk) disable iff (!resetn)
        valid |=> !valid)
    else begin
        $error("valid stayed high for more than one cycle");
        failCount++;
    end

    // Downstream full in sDone holds the record back
    stallHolds: assert property (@(posedge clk) disable iff (!resetn)
        (state == sDone) && outputFull |=> !valid)
    else begin
        $error("valid rose while the output was stalled");
        failCount++;
    end

    doneToValid: assert property (@(posedge clk) disable iff (!resetn)
        $past(candDone && (state == sSurfacing)) && !outputFull |=> valid)
    else begin
        $error("valid did not follow candDone by two cycles");
        failCount++;
    end

    quietAfterReset: assert property (@(posedge clk) disable iff (!resetn)
        !rayArrived |-> !valid && !rayStart && !fifoFull)
    else begin
        $error("output strobes active before any ray arrived");
        failCount++;
    end

endmodule

bind surfaceUnit surfaceUnit_asserts i_asserts (
    .clk        (clk),
    .resetn     (resetn),
    .addInput   (addInput),
    .fifoFull   (fifoFull),
    .rayStart   (rayStart),
    .candDone   (candDone),
    .outputFull (outputFull),
    .valid      (valid),
    .state      (i_control.state)
);

// ==== testbench/tbSurfaceUnit.sv ====
/* Surfacing stage testbench */

`timescale 1ns/1ns

module tbSurfaceUnit import surfacePkg::*; ();

    localparam int        NUM_RAYS    = 40;
    localparam int        WAIT_LIMIT  = 200;
    localparam int        FRAC_BITS   = 16;
    localparam int        CHECKER_BIT = 18;
    localparam colorT     CLEAR_COLOR = 24'h20_40_60;
    localparam primIndexT GROUND_PRIM = 12'd5;
    localparam fixedT     LIGHT_X     = 32'sh0000_4000;
    localparam fixedT     LIGHT_Y     = 32'shFFFF_2000;
    localparam fixedT     LIGHT_Z     = 32'sh0000_6000;

    logic        clk;
    logic        resetn;
    logic        addInput, hitValid, candDone, outputFull, cfgWrite;
    fixedT       rayOrigX, rayOrigY, rayOrigZ, rayDirX, rayDirY, rayDirZ, hitT;
    pixelT       pixelX, pixelY, outPixelX, outPixelY;
    bounceT      bounceLevel, outBounce;
    colorT       lastColor, hitColor, outColor, outLastColor;
    primIndexT   hitPrim, outPrim;
    surfaceTypeT hitSurface, outSurface;
    cfgAddrT     cfgAddr;
    logic [31:0] cfgData;
    logic        fifoFull, rayStart, valid;
    fixedT       hitPosX, hitPosY, hitPosZ, shadowDirX, shadowDirY, shadowDirZ;

    // Rays as sent and the expected best hit per ray
    fixedT       origX [NUM_RAYS], origY [NUM_RAYS], origZ [NUM_RAYS];
    fixedT       dirX [NUM_RAYS], dirY [NUM_RAYS], dirZ [NUM_RAYS];
    pixelT       pixX [NUM_RAYS], pixY [NUM_RAYS];
    bounceT      bounce [NUM_RAYS];
    colorT       lastCol [NUM_RAYS], expColor [NUM_RAYS];
    fixedT       expT [NUM_RAYS];
    surfaceTypeT expSurface [NUM_RAYS];
    primIndexT   expPrim [NUM_RAYS];

    int seed = 17939;
    int stallSeed = 17939 + 1;
    int mismatches = 0;
    int timeouts = 0;
    int extras = 0;
    int outCount = 0;

    clockGen i_clockGen (.clk(clk), .resetn(resetn));

    surfaceUnit #(.FRAC_BITS(FRAC_BITS), .CHECKER_BIT(CHECKER_BIT)) i_dut (
        .clk(clk), .resetn(resetn), .addInput(addInput),
        .rayOrigX(rayOrigX), .rayOrigY(rayOrigY), .rayOrigZ(rayOrigZ),
        .rayDirX(rayDirX), .rayDirY(rayDirY), .rayDirZ(rayDirZ),
        .pixelX(pixelX), .pixelY(pixelY), .bounceLevel(bounceLevel),
        .lastColor(lastColor), .fifoFull(fifoFull), .rayStart(rayStart),
        .hitValid(hitValid), .hitT(hitT), .hitPrim(hitPrim), .hitSurface(hitSurface),
        .hitColor(hitColor), .candDone(candDone), .outputFull(outputFull),
        .valid(valid), .outColor(outColor), .outSurface(outSurface), .outPrim(outPrim),
        .hitPosX(hitPosX), .hitPosY(hitPosY), .hitPosZ(hitPosZ),
        .shadowDirX(shadowDirX), .shadowDirY(shadowDirY), .shadowDirZ(shadowDirZ),
        .outPixelX(outPixelX), .outPixelY(outPixelY), .outBounce(outBounce),
        .outLastColor(outLastColor), .cfgWrite(cfgWrite), .cfgAddr(cfgAddr),
        .cfgData(cfgData)
    );

    // --------------------
    // Reference model

    // Origin plus T times direction, Q16.16
    function automatic fixedT axisHit(input fixedT orig, input fixedT dir, input fixedT t);
        longint prod;
        prod = longint'(t) * longint'(dir);
        return orig + 32'(prod >>> FRAC_BITS);
    endfunction

    function automatic colorT halveColor(input colorT c);
        logic [7:0] red, green, blue;
        red   = c[23:16] >> 1;
        green = c[15:8] >> 1;
        blue  = c[7:0] >> 1;
        return {red, green, blue};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic checkRecord(input int k);
        fixedT ex, ey, ez;
        colorT ec;
        ex = axisHit(origX[k], dirX[k], expT[k]);
        ey = axisHit(origY[k], dirY[k], expT[k]);
        ez = axisHit(origZ[k], dirZ[k], expT[k]);
        ec = expColor[k];
        // Dark square of the ground checkerboard
        if (expSurface[k] != stNone && expPrim[k] == GROUND_PRIM &&
            ex[CHECKER_BIT] != ez[CHECKER_BIT]) begin
            ec = halveColor(ec);
        end
        checkValue("outColor", 32'(outColor), 32'(ec));
        checkValue("outSurface", 32'(outSurface), 32'(expSurface[k]));
        checkValue("outPrim", 32'(outPrim), 32'(expPrim[k]));
        checkValue("hitPosX", hitPosX, ex);
        checkValue("hitPosY", hitPosY, ey);
        checkValue("hitPosZ", hitPosZ, ez);
        checkValue("shadowDirX", shadowDirX, LIGHT_X);
        checkValue("shadowDirY", shadowDirY, LIGHT_Y);
        checkValue("shadowDirZ", shadowDirZ, LIGHT_Z);
        checkValue("outPixelX", 32'(outPixelX), 32'(pixX[k]));
        checkValue("outPixelY", 32'(outPixelY), 32'(pixY[k]));
        checkValue("outBounce", 32'(outBounce), 32'(bounce[k]));
        checkValue("outLastColor", 32'(outLastColor), 32'(lastCol[k]));
    endtask

    always @(negedge clk) begin
        if (resetn && valid) begin
            if (outCount < NUM_RAYS) begin
                checkRecord(outCount);
            end else begin
                $display("unexpected output record at %0t ns with no ray outstanding", $time);
                extras++;
            end
            outCount++;
        end
    end

    // --------------------
    // Stimulus

    task automatic writeConfig(input cfgAddrT addr, input logic [31:0] data);
        @(posedge clk);
        cfgWrite <= 1'b1;
        cfgAddr  <= addr;
        cfgData  <= data;
        @(posedge clk);
        cfgWrite <= 1'b0;
    endtask

    task automatic sendRay(input int k);
        @(posedge clk);
        origX[k] = $random(seed) % 32'sh0010_0000;
        origY[k] = $random(seed) % 32'sh0010_0000;
        origZ[k] = $random(seed) % 32'sh0010_0000;
        dirX[k] = $random(seed) % 32'sh0002_0000;
        dirY[k] = $random(seed) % 32'sh0002_0000;
        dirZ[k] = $random(seed) % 32'sh0002_0000;
        pixX[k] = 16'($random(seed));
        pixY[k] = 16'($random(seed));
        bounce[k] = 4'($random(seed));
        lastCol[k] = 24'($random(seed));
        addInput    <= 1'b1;
        rayOrigX    <= origX[k];
        rayOrigY    <= origY[k];
        rayOrigZ    <= origZ[k];
        rayDirX     <= dirX[k];
        rayDirY     <= dirY[k];
        rayDirZ     <= dirZ[k];
        pixelX      <= pixX[k];
        pixelY      <= pixY[k];
        bounceLevel <= bounce[k];
        lastColor   <= lastCol[k];
        @(posedge clk);
        addInput <= 1'b0;
    endtask

    // Random candidates, the last one possibly together with candDone
    task automatic sendCandidates(input int k);
        int          nCand;
        logic [31:0] r;
        logic        doneSent;
        fixedT       t, bestT;
        surfaceTypeT s;
        primIndexT   p;
        colorT       c;
        expSurface[k] = stNone;
        expPrim[k] = '0;
        expColor[k] = CLEAR_COLOR;
        bestT = FIXED_MAX;
        nCand = $unsigned($random(seed)) % 6;
        r = $random(seed);
        doneSent = r[0] && (nCand > 0);
        for (int i = 0; i < nCand; i++) begin
            @(posedge clk);
            r = $random(seed);
            if (r[12] && i > 0) begin
                hitValid <= 1'b0;
                @(posedge clk);
            end
            // Few distinct T values so equal T happens often
            t = {12'd0, r[3:0], 16'h8000};
            case (r[5:4])
                2'd1: s = stDiffuse;
                2'd2: s = stReflect;
                default: s = stNone;
            endcase
            p = r[6] ? GROUND_PRIM : {8'd0, r[11:8]};
            c = 24'($random(seed));
            hitValid   <= 1'b1;
            hitT       <= t;
            hitSurface <= s;
            hitPrim    <= p;
            hitColor   <= c;
            candDone   <= doneSent && (i == nCand - 1);
            if (s != stNone && t < bestT) begin
                bestT = t;
                expSurface[k] = s;
                expPrim[k] = p;
                expColor[k] = c;
            end
        end
        expT[k] = bestT;
        @(posedge clk);
        hitValid <= 1'b0;
        if (!doneSent) begin
            candDone <= 1'b1;
            @(posedge clk);
        end
        candDone <= 1'b0;
    endtask

    task automatic waitReset(output logic ok);
        int cycles;
        cycles = 0;
        while (resetn !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        ok = (resetn === 1'b1);
        if (!ok) begin
            $display("timed out waiting for reset to be released");
            timeouts++;
        end
    endtask

    task automatic waitRayStart(input int k, output logic ok);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!rayStart && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        ok = rayStart;
        if (!ok) begin
            $display("timed out waiting for rayStart of ray %0d", k);
            timeouts++;
        end
    endtask

    task automatic waitDrain(output logic ok);
        int cycles;
        cycles = 0;
        while (outCount < NUM_RAYS && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        ok = (outCount >= NUM_RAYS);
        if (!ok) begin
            $display("timed out waiting for output records, got %0d of %0d", outCount, NUM_RAYS);
            timeouts++;
        end
    endtask

    // Downstream stalls in random stretches
    initial begin : backPressure
        int lowLen;
        int highLen;
        outputFull <= 1'b0;
        repeat (20) @(posedge clk);
        forever begin
            lowLen = 2 + ($unsigned($random(stallSeed)) % 10);
            highLen = 1 + ($unsigned($random(stallSeed)) % 6);
            repeat (lowLen) @(posedge clk);
            outputFull <= 1'b1;
            repeat (highLen) @(posedge clk);
            outputFull <= 1'b0;
        end
    end

    initial begin : stimulus
        logic ok;
        addInput <= 1'b0;
        {rayOrigX, rayOrigY, rayOrigZ} <= '0;
        {rayDirX, rayDirY, rayDirZ} <= '0;
        {pixelX, pixelY, bounceLevel, lastColor} <= '0;
        hitValid   <= 1'b0;
        hitT       <= '0;
        hitPrim    <= '0;
        hitSurface <= stNone;
        hitColor   <= '0;
        candDone   <= 1'b0;
        cfgWrite   <= 1'b0;
        cfgAddr    <= '0;
        cfgData    <= '0;
        waitReset(ok);
        if (ok) begin
            writeConfig(CFG_CLEAR_COLOR, {8'd0, CLEAR_COLOR});
            writeConfig(CFG_LIGHT_X, LIGHT_X);
            writeConfig(CFG_LIGHT_Y, LIGHT_Y);
            writeConfig(CFG_LIGHT_Z, LIGHT_Z);
            writeConfig(CFG_GROUND_PRIM, {20'd0, GROUND_PRIM});
            // Unmapped address must leave the state alone
            writeConfig(3'd7, 32'hFFFF_FFFF);
            sendRay(0);
            for (int k = 0; k < NUM_RAYS; k++) begin
                waitRayStart(k, ok);
                if (!ok) begin
                    break;
                end
                // Next ray waits in the slot while this one surfaces
                if (k + 1 < NUM_RAYS) begin
                    sendRay(k + 1);
                end
                sendCandidates(k);
            end
            if (ok) begin
                waitDrain(ok);
            end
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d extra records, %0d assertion failures",
                 mismatches, timeouts, extras, i_dut.i_asserts.failCount);
        if (mismatches == 0 && timeouts == 0 && extras == 0 &&
            i_dut.i_asserts.failCount == 0 && outCount == NUM_RAYS) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
